/* vid_settings.svh */
// field widths, register reset values, video latency and APB register addresses
`ifndef VID_SETTINGS_SVH
`define VID_SETTINGS_SVH

// field widths
`define VID_DIM_W   12
`define VID_DATA_W  24
`define SYNC_CNT_W  16
`define APB_ADDR_W  8

// size registers out of reset, full 1080p frame
`define RST_WIDTH   12'd1920
`define RST_HEIGHT  12'd1080

// clk_sys cycles from i_vid to o_vid
`define VID_LATENCY 3

// register map, one word each
`define ADDR_CFG    8'h00
`define ADDR_WIDTH  8'h04
`define ADDR_HEIGHT 8'h08
`define ADDR_HSET   8'h0C
`define ADDR_VSET   8'h10
// read-only window bounds, max in 27:16 and min in 11:0
`define ADDR_HWIN   8'h14
`define ADDR_VWIN   8'h18

`endif

/* vid_pkg.sv */
// packed struct types for video beats, config flags, frame sizes, window bounds and APB
`include "vid_settings.svh"

package vid_pkg;

	// one clk_sys beat of video
	typedef struct packed {
		logic [`VID_DATA_W-1:0] data;
		logic                   hs;
		logic                   vs;
		logic                   de;
	} vid_beat_t;

	// CFG word, csync_en in bit 0
	typedef struct packed {
		logic vs_neg;
		logic hs_neg;
		logic csync_en;
	} vid_cfg_t;

	// active size and requested output size
	typedef struct packed {
		logic [`VID_DIM_W-1:0] width;
		logic [`VID_DIM_W-1:0] height;
		logic [`VID_DIM_W-1:0] hset;
		logic [`VID_DIM_W-1:0] vset;
	} vid_size_t;

	// inclusive window bounds in pixels and lines
	typedef struct packed {
		logic [`VID_DIM_W-1:0] hmin;
		logic [`VID_DIM_W-1:0] hmax;
		logic [`VID_DIM_W-1:0] vmin;
		logic [`VID_DIM_W-1:0] vmax;
	} vid_win_t;

	// APB request from the bus master
	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`APB_ADDR_W-1:0] paddr;
		logic [31:0]            pwdata;
	} apb_req_t;

	// APB response back to the master
	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

endpackage

/* apb_cfg_regs.sv */
// APB slave with CFG, WIDTH, HEIGHT, HSET, VSET and read-only window bound registers
`timescale 1ns/1ps
`include "vid_settings.svh"

module apb_cfg_regs (
	input  logic               clk_sys,
	input  logic               resetd,
	input  vid_pkg::apb_req_t  i_apb,
	output vid_pkg::apb_rsp_t  o_apb,
	input  vid_pkg::vid_win_t  i_win,
	output vid_pkg::vid_cfg_t  o_cfg,
	output vid_pkg::vid_size_t o_size
);

	localparam int PAD_W = 32 - `VID_DIM_W;
	localparam int CFG_W = $bits(vid_pkg::vid_cfg_t);

	vid_pkg::vid_cfg_t  cfg_q;
	vid_pkg::vid_size_t size_q;

	logic        access;
	logic        addr_hit;
	logic        addr_ro;
	logic        err;
	logic        wr_en;
	logic [31:0] rd_data;
	logic [31:0] rd_out;

	// access phase of a transfer, never stalled
	assign access = i_apb.psel & i_apb.penable;

	////////////////////////////////////////////////////////////
	// address decode and read mux
	////////////////////////////////////////////////////////////
	always_comb begin
		addr_hit = 1'b1;
		addr_ro  = 1'b0;
		rd_data  = '0;
		case (i_apb.paddr)
			`ADDR_CFG:    rd_data = {{(32 - CFG_W){1'b0}}, cfg_q};
			`ADDR_WIDTH:  rd_data = {{PAD_W{1'b0}}, size_q.width};
			`ADDR_HEIGHT: rd_data = {{PAD_W{1'b0}}, size_q.height};
			`ADDR_HSET:   rd_data = {{PAD_W{1'b0}}, size_q.hset};
			`ADDR_VSET:   rd_data = {{PAD_W{1'b0}}, size_q.vset};
			`ADDR_HWIN: begin
				addr_ro = 1'b1;
				rd_data = {4'd0, i_win.hmax, 4'd0, i_win.hmin};
			end
			`ADDR_VWIN: begin
				addr_ro = 1'b1;
				rd_data = {4'd0, i_win.vmax, 4'd0, i_win.vmin};
			end
			default: addr_hit = 1'b0;
		endcase
	end

	// bad address, or write to a window register
	assign err    = access & (~addr_hit | (i_apb.pwrite & addr_ro));
	assign wr_en  = access & i_apb.pwrite & addr_hit & ~addr_ro;
	assign rd_out = (access & ~i_apb.pwrite & ~err) ? rd_data : '0;

	assign o_apb = '{pready: 1'b1, pslverr: err, prdata: rd_out};

	////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cfg_q  <= '0;
			size_q <= '{width: `RST_WIDTH, height: `RST_HEIGHT, hset: '0, vset: '0};
		end else if (wr_en) begin
			case (i_apb.paddr)
				`ADDR_CFG:    cfg_q <= i_apb.pwdata[CFG_W-1:0];
				`ADDR_WIDTH:  size_q.width <= i_apb.pwdata[`VID_DIM_W-1:0];
				`ADDR_HEIGHT: size_q.height <= i_apb.pwdata[`VID_DIM_W-1:0];
				`ADDR_HSET:   size_q.hset <= i_apb.pwdata[`VID_DIM_W-1:0];
				`ADDR_VSET:   size_q.vset <= i_apb.pwdata[`VID_DIM_W-1:0];
				default: ;
			endcase
		end
	end

	assign o_cfg  = cfg_q;
	assign o_size = size_q;

endmodule

/* window_calc.sv */
// centred display window from the frame size and the requested output size
`timescale 1ns/1ps
`include "vid_settings.svh"

module window_calc (
	input  logic               clk_sys,
	input  logic               resetd,
	input  vid_pkg::vid_size_t i_size,
	output vid_pkg::vid_win_t  o_win
);

	logic [`VID_DIM_W-1:0] full_w_q;
	logic [`VID_DIM_W-1:0] full_h_q;
	logic [`VID_DIM_W-1:0] disp_w_q;
	logic [`VID_DIM_W-1:0] disp_h_q;
	logic [`VID_DIM_W-1:0] lo_w;
	logic [`VID_DIM_W-1:0] lo_h;
	vid_pkg::vid_win_t     win_q;

	// requested size only wins when set and smaller than the frame
	function automatic logic [`VID_DIM_W-1:0] clamp_dim(
		input logic [`VID_DIM_W-1:0] full,
		input logic [`VID_DIM_W-1:0] req
	);
		clamp_dim = (req != '0 && req < full) ? req : full;
	endfunction

	// half the unused margin, rounded down
	function automatic logic [`VID_DIM_W-1:0] centre_lo(
		input logic [`VID_DIM_W-1:0] full,
		input logic [`VID_DIM_W-1:0] disp
	);
		logic [`VID_DIM_W-1:0] margin;
		margin    = full - disp;
		centre_lo = margin >> 1;
	endfunction

	assign lo_w = centre_lo(full_w_q, disp_w_q);
	assign lo_h = centre_lo(full_h_q, disp_h_q);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			full_w_q <= `RST_WIDTH;
			full_h_q <= `RST_HEIGHT;
			disp_w_q <= `RST_WIDTH;
			disp_h_q <= `RST_HEIGHT;
			win_q    <= '{hmin: '0, hmax: `RST_WIDTH - 12'd1,
				vmin: '0, vmax: `RST_HEIGHT - 12'd1};
		end else begin
			// stage 1, clamp
			full_w_q <= i_size.width;
			full_h_q <= i_size.height;
			disp_w_q <= clamp_dim(i_size.width, i_size.hset);
			disp_h_q <= clamp_dim(i_size.height, i_size.vset);
			// stage 2, centre
			win_q.hmin <= lo_w;
			win_q.hmax <= lo_w + disp_w_q - 1'b1;
			win_q.vmin <= lo_h;
			win_q.vmax <= lo_h + disp_h_q - 1'b1;
		end
	end

	assign o_win = win_q;

endmodule

/* sync_recover.sv */
// sync polarity detection, active-high hs/vs normalisation and composite sync
`timescale 1ns/1ps
`include "vid_settings.svh"

module sync_recover (
	input  logic               clk_sys,
	input  logic               resetd,
	input  vid_pkg::vid_beat_t i_vid,
	output vid_pkg::vid_beat_t o_vid,
	output logic               o_csync
);

	vid_pkg::vid_beat_t in_q1;
	vid_pkg::vid_beat_t in_q2;

	// bit 0 is hs, bit 1 is vs
	logic [1:0] sync_q1;
	logic [1:0] sync_q2;
	logic [1:0] pol;
	logic [1:0] sync_norm;

	logic                   csync_hs;
	logic [`SYNC_CNT_W-1:0] h_cnt;
	logic [`SYNC_CNT_W-1:0] line_len;
	logic [`SYNC_CNT_W-1:0] hs_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			in_q1 <= '0;
			in_q2 <= '0;
		end else begin
			in_q1 <= i_vid;
			in_q2 <= in_q1;
		end
	end

	assign sync_q1   = {in_q1.vs, in_q1.hs};
	assign sync_q2   = {in_q2.vs, in_q2.hs};
	assign sync_norm = sync_q1 ^ pol;

	////////////////////////////////////////////////////////////
	// polarity, invert when the high phase is the longer one
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < 2; i++) begin : g_pol
		logic [`SYNC_CNT_W-1:0] run_cnt;
		logic [`SYNC_CNT_W-1:0] hi_len;
		logic [`SYNC_CNT_W-1:0] lo_len;
		logic                   pol_q;

		always_ff @(posedge clk_sys) begin
			if (resetd) begin
				run_cnt <= '0;
				hi_len  <= '0;
				lo_len  <= '0;
				pol_q   <= 1'b0;
			end else begin
				if (sync_q1[i] != sync_q2[i])
					run_cnt <= '0;
				else if (~&run_cnt)
					run_cnt <= run_cnt + 1'b1;
				// rise ends a low phase, fall ends a high phase
				if (sync_q1[i] & ~sync_q2[i])
					lo_len <= run_cnt;
				if (~sync_q1[i] & sync_q2[i])
					hi_len <= run_cnt;
				pol_q <= hi_len > lo_len;
			end
		end

		assign pol[i] = pol_q;
	end

	////////////////////////////////////////////////////////////
	// output register and composite sync
	////////////////////////////////////////////////////////////
	// o_vid.hs doubles as the previous normalised hs
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_vid    <= '0;
			csync_hs <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			o_vid.data <= in_q1.data;
			o_vid.de   <= in_q1.de;
			o_vid.hs   <= sync_norm[0];
			o_vid.vs   <= sync_norm[1];

			h_cnt <= h_cnt + 1'b1;
			if (sync_norm[0] != o_vid.hs) begin
				h_cnt <= '0;
				if (sync_norm[0]) begin
					line_len <= h_cnt - hs_len;
					csync_hs <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end

			// during vsync the hs term is shifted by one pulse width
			if (~sync_norm[1])
				csync_hs <= sync_norm[0];
			else if (h_cnt == line_len)
				csync_hs <= 1'b1;
		end
	end

	assign o_csync = csync_hs ^ o_vid.vs;

endmodule

/* video_out_mux.sv */
// column/row counting, window blanking, hsync select and output polarity
`timescale 1ns/1ps
`include "vid_settings.svh"

module video_out_mux (
	input  logic               clk_sys,
	input  logic               resetd,
	input  vid_pkg::vid_beat_t i_vid,
	input  logic               i_csync,
	input  vid_pkg::vid_cfg_t  i_cfg,
	input  vid_pkg::vid_win_t  i_win,
	output vid_pkg::vid_beat_t o_vid
);

	logic [`VID_DIM_W-1:0] col_q;
	logic [`VID_DIM_W-1:0] row_q;
	logic                  de_q;
	logic                  vs_q;
	logic                  in_h;
	logic                  in_v;
	logic                  win_de;
	logic                  hs_sel;

	////////////////////////////////////////////////////////////
	// pixel and line position
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			col_q <= '0;
			row_q <= '0;
			de_q  <= 1'b0;
			vs_q  <= 1'b0;
		end else begin
			de_q <= i_vid.de;
			vs_q <= i_vid.vs;
			// col_q is the index of the current active pixel
			if (i_vid.de)
				col_q <= col_q + 1'b1;
			else
				col_q <= '0;
			// new frame on vs rise, next line at end of de
			if (i_vid.vs & ~vs_q)
				row_q <= '0;
			else if (de_q & ~i_vid.de)
				row_q <= row_q + 1'b1;
		end
	end

	assign in_h   = (col_q >= i_win.hmin) && (col_q <= i_win.hmax);
	assign in_v   = (row_q >= i_win.vmin) && (row_q <= i_win.vmax);
	assign win_de = i_vid.de & in_h & in_v;
	assign hs_sel = i_cfg.csync_en ? i_csync : i_vid.hs;

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_vid <= '0;
		end else begin
			o_vid.de   <= win_de;
			o_vid.data <= win_de ? i_vid.data : '0;
			o_vid.hs   <= hs_sel ^ i_cfg.hs_neg;
			o_vid.vs   <= i_vid.vs ^ i_cfg.vs_neg;
		end
	end

endmodule

/* video_sys_top.sv */
// top level: APB registers, window calculation, sync recovery and output mux
`timescale 1ns/1ps

module video_sys_top (
	input  logic               clk_sys,
	input  logic               resetd,
	input  vid_pkg::apb_req_t  i_apb,
	output vid_pkg::apb_rsp_t  o_apb,
	input  vid_pkg::vid_beat_t i_vid,
	output vid_pkg::vid_beat_t o_vid
);

	vid_pkg::vid_cfg_t  cfg;
	vid_pkg::vid_size_t dim_size;
	vid_pkg::vid_win_t  win;
	vid_pkg::vid_beat_t norm_vid;
	logic               csync;

	apb_cfg_regs i_apb_cfg_regs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_apb   (i_apb),
		.o_apb   (o_apb),
		.i_win   (win),
		.o_cfg   (cfg),
		.o_size  (dim_size)
	);

	window_calc i_window_calc (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_size  (dim_size),
		.o_win   (win)
	);

	// 2 cycles here plus 1 in the mux
	sync_recover i_sync_recover (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_vid   (i_vid),
		.o_vid   (norm_vid),
		.o_csync (csync)
	);

	video_out_mux i_video_out_mux (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_vid   (norm_vid),
		.i_csync (csync),
		.i_cfg   (cfg),
		.i_win   (win),
		.o_vid   (o_vid)
	);

endmodule

/* video_sys_assertions.sv */
// concurrent assertions on the APB response and the output video of the top level
`timescale 1ns/1ps
`include "vid_settings.svh"

module video_sys_assertions (
	input logic               clk_sys,
	input logic               resetd,
	input vid_pkg::apb_req_t  i_apb,
	input vid_pkg::apb_rsp_t  o_apb,
	input vid_pkg::vid_beat_t i_vid,
	input vid_pkg::vid_beat_t o_vid
);

	logic access;
	logic addr_mapped;
	logic addr_ro;

	// number of assertion failures so far
	int fail_cnt = 0;

	assign access      = i_apb.psel & i_apb.penable;
	assign addr_ro     = (i_apb.paddr == `ADDR_HWIN) || (i_apb.paddr == `ADDR_VWIN);
	assign addr_mapped = addr_ro || (i_apb.paddr == `ADDR_CFG) ||
		(i_apb.paddr == `ADDR_WIDTH) || (i_apb.paddr == `ADDR_HEIGHT) ||
		(i_apb.paddr == `ADDR_HSET) || (i_apb.paddr == `ADDR_VSET);

	// no wait states
	a_pready : assert property (@(posedge clk_sys) disable iff (resetd)
		access |-> o_apb.pready)
		else begin
			$error("pready low in an access cycle");
			fail_cnt++;
		end

	// first cycle out of reset
	a_reset_out : assert property (@(posedge clk_sys)
		(!resetd && $past(resetd)) |-> (o_vid == '0))
		else begin
			$error("o_vid not cleared by reset");
			fail_cnt++;
		end

	a_blank_data : assert property (@(posedge clk_sys) disable iff (resetd)
		!o_vid.de |-> (o_vid.data == '0))
		else begin
			$error("o_vid.data nonzero while de low");
			fail_cnt++;
		end

	// a displayed pixel must come from an active input pixel
	a_de_source : assert property (@(posedge clk_sys) disable iff (resetd)
		o_vid.de |-> $past(i_vid.de, `VID_LATENCY))
		else begin
			$error("o_vid.de high without an active input pixel");
			fail_cnt++;
		end

	a_slverr_cause : assert property (@(posedge clk_sys) disable iff (resetd)
		o_apb.pslverr |-> (access && (!addr_mapped || (i_apb.pwrite && addr_ro))))
		else begin
			$error("pslverr without a bad address or read-only write");
			fail_cnt++;
		end

endmodule

bind video_sys_top video_sys_assertions i_video_sys_assertions (.*);

/* tb_video_sys.sv */
// testbench with clock, reset, APB tasks, video source, reference model, checks and timeout
`timescale 1ns/1ps
`include "vid_settings.svh"

module tb_video_sys;

	localparam int LINE        = 24;
	localparam int FRAME       = LINE * 12;
	localparam int CYCLE_LIMIT = 6000;

	// one source beat with its position and active-high syncs
	typedef struct packed {
		logic [23:0] data;
		logic        de;
		logic        hs_act;
		logic        vs_act;
		logic [11:0] x;
		logic [11:0] y;
	} src_t;

	logic               clk_sys;
	logic               resetd;
	vid_pkg::apb_req_t  apb_req;
	vid_pkg::apb_rsp_t  apb_rsp;
	vid_pkg::vid_beat_t vid_in;
	vid_pkg::vid_beat_t vid_out;

	src_t        hist [0:3];
	int          gx;
	int          gy;
	logic        inv_sync;
	logic        chk_mask;
	logic        chk_sync;
	logic        chk_csync;
	logic [11:0] m_hset;
	logic [11:0] m_vset;
	logic        m_hs_neg;
	logic        m_vs_neg;
	string       cur_test;
	int          test_errs;
	int          n_tests;
	int          n_failed;
	int          n_errs;
	int          n_assert;
	int          cycle_cnt;

	video_sys_top i_video_sys_top (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_apb   (apb_req),
		.o_apb   (apb_rsp),
		.i_vid   (vid_in),
		.o_vid   (vid_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// reference rules
	////////////////////////////////////////////////////////////
	function automatic logic [11:0] disp_size(input logic [11:0] full, input logic [11:0] req);
		return (req != 12'd0 && req < full) ? req : full;
	endfunction

	function automatic logic [11:0] win_lo(input logic [11:0] full, input logic [11:0] req);
		logic [11:0] margin;
		margin = full - disp_size(full, req);
		return margin >> 1;
	endfunction

	function automatic logic [11:0] win_hi(input logic [11:0] full, input logic [11:0] req);
		return win_lo(full, req) + disp_size(full, req) - 12'd1;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act)
		else begin
			$display("** Error %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else begin
			$display("%s: %s", cur_test, what);
			test_errs++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// video source with 16x8 active in a 24x12 frame
	////////////////////////////////////////////////////////////
	always @(posedge clk_sys) begin
		src_t b;
		b.x      = 12'(gx);
		b.y      = 12'(gy);
		b.de     = (gx < 16) && (gy < 8);
		b.hs_act = (gx == 18) || (gx == 19);
		b.vs_act = (gy == 9) || (gy == 10);
		b.data   = 24'($urandom);
		vid_in  <= '{data: b.data, hs: b.hs_act ^ inv_sync, vs: b.vs_act ^ inv_sync, de: b.de};
		hist[0] <= b;
		hist[1] <= hist[0];
		hist[2] <= hist[1];
		hist[3] <= hist[2];
		gx <= (gx == LINE - 1) ? 0 : gx + 1;
		if (gx == LINE - 1)
			gy <= (gy == 11) ? 0 : gy + 1;
	end

	// hist[3] lines up with o_vid
	always @(negedge clk_sys) begin
		src_t        h;
		logic        exp_de;
		logic [11:0] hmin;
		logic [11:0] hmax;
		logic [11:0] vmin;
		logic [11:0] vmax;
		h    = hist[3];
		hmin = win_lo(12'd16, m_hset);
		hmax = win_hi(12'd16, m_hset);
		vmin = win_lo(12'd8, m_vset);
		vmax = win_hi(12'd8, m_vset);
		exp_de = h.de && h.x >= hmin && h.x <= hmax && h.y >= vmin && h.y <= vmax;
		if (chk_mask) begin
			check_value("o_vid.de", 32'(exp_de), 32'(vid_out.de));
			check_value("o_vid.data", exp_de ? 32'(h.data) : 32'd0, 32'(vid_out.data));
		end
		if (chk_sync) begin
			check_value("o_vid.hs", 32'(h.hs_act ^ m_hs_neg), 32'(vid_out.hs));
			check_value("o_vid.vs", 32'(h.vs_act ^ m_vs_neg), 32'(vid_out.vs));
		end
		if (chk_csync) begin
			if (!h.vs_act)
				check_value("csync outside vsync", 32'(h.hs_act), 32'(vid_out.hs));
			else if (h.x == 12'd18)
				check_value("csync at hs start", 32'd1, 32'(vid_out.hs));
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// APB access
	////////////////////////////////////////////////////////////
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk_sys);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk_sys);
		apb_req.penable <= 1'b1;
		@(negedge clk_sys);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check_true(apb_rsp.pready, "pready low during an access cycle");
		@(posedge clk_sys);
		apb_req <= '0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b1, addr, data, rdata, err);
		check_value($sformatf("pslverr on write 0x%0h", addr), 32'(exp_err), 32'(err));
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
		input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b0, addr, 32'd0, rdata, err);
		check_value($sformatf("pslverr on read 0x%0h", addr), 32'(exp_err), 32'(err));
		check_value($sformatf("read 0x%0h", addr), exp, rdata);
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		n_tests++;
		n_errs += test_errs;
		if (test_errs != 0)
			n_failed++;
		$display("test %s: %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "FAILED",
			test_errs);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(32'h7d4d_b983));
		resetd    = 1'b1;
		apb_req   = '0;
		vid_in    = '0;
		gx        = 0;
		gy        = 0;
		inv_sync  = 1'b0;
		chk_mask  = 1'b0;
		chk_sync  = 1'b0;
		chk_csync = 1'b0;
		m_hset    = 12'd0;
		m_vset    = 12'd0;
		m_hs_neg  = 1'b0;
		m_vs_neg  = 1'b0;
		cycle_cnt = 0;
		n_tests   = 0;
		n_failed  = 0;
		n_errs    = 0;
		n_assert  = 0;
		for (int i = 0; i < 4; i++)
			hist[i] = '0;
		wait_cycles(8);
		resetd <= 1'b0;

		begin_test("reset_values");
		read_expect(`ADDR_CFG, 32'd0, 1'b0);
		read_expect(`ADDR_WIDTH, 32'd1920, 1'b0);
		read_expect(`ADDR_HEIGHT, 32'd1080, 1'b0);
		read_expect(`ADDR_HSET, 32'd0, 1'b0);
		read_expect(`ADDR_VSET, 32'd0, 1'b0);
		read_expect(`ADDR_HWIN, {16'd1919, 16'd0}, 1'b0);
		read_expect(`ADDR_VWIN, {16'd1079, 16'd0}, 1'b0);
		write_reg(`ADDR_WIDTH, 32'd16, 1'b0);
		write_reg(`ADDR_HEIGHT, 32'd8, 1'b0);
		write_reg(`ADDR_CFG, 32'd6, 1'b0);
		write_reg(`ADDR_HSET, 32'd5, 1'b0);
		read_expect(`ADDR_WIDTH, 32'd16, 1'b0);
		read_expect(`ADDR_HEIGHT, 32'd8, 1'b0);
		read_expect(`ADDR_CFG, 32'd6, 1'b0);
		read_expect(`ADDR_HSET, 32'd5, 1'b0);
		write_reg(`ADDR_CFG, 32'd0, 1'b0);
		write_reg(`ADDR_HSET, 32'd0, 1'b0);
		read_expect(8'h1C, 32'd0, 1'b1);
		write_reg(8'h1C, 32'd1, 1'b1);
		write_reg(`ADDR_HWIN, 32'hFFFF_FFFF, 1'b1);
		read_expect(`ADDR_HWIN, {16'd15, 16'd0}, 1'b0);
		end_test();

		begin_test("window_calc");
		write_reg(`ADDR_HSET, 32'd20, 1'b0);
		wait_cycles(2);
		read_expect(`ADDR_HWIN, {16'd15, 16'd0}, 1'b0);
		write_reg(`ADDR_HSET, 32'd10, 1'b0);
		write_reg(`ADDR_VSET, 32'd4, 1'b0);
		m_hset = 12'd10;
		m_vset = 12'd4;
		wait_cycles(2);
		read_expect(`ADDR_HWIN, {16'd12, 16'd3}, 1'b0);
		read_expect(`ADDR_VWIN, {16'd5, 16'd2}, 1'b0);
		end_test();

		begin_test("window_mask");
		wait_cycles(FRAME);
		chk_mask = 1'b1;
		wait_cycles(FRAME);
		chk_mask = 1'b0;
		end_test();

		// active-low source needs one frame to learn, plus margin
		begin_test("polarity");
		@(posedge clk_sys);
		inv_sync <= 1'b1;
		wait_cycles(2 * FRAME);
		chk_sync = 1'b1;
		wait_cycles(FRAME);
		chk_sync = 1'b0;
		write_reg(`ADDR_CFG, 32'd6, 1'b0);
		m_hs_neg = 1'b1;
		m_vs_neg = 1'b1;
		wait_cycles(4);
		chk_sync = 1'b1;
		wait_cycles(FRAME);
		chk_sync = 1'b0;
		end_test();

		begin_test("csync");
		write_reg(`ADDR_CFG, 32'd1, 1'b0);
		m_hs_neg = 1'b0;
		m_vs_neg = 1'b0;
		wait_cycles(4);
		chk_csync = 1'b1;
		wait_cycles(FRAME);
		chk_csync = 1'b0;
		end_test();

		n_assert = i_video_sys_top.i_video_sys_assertions.fail_cnt;
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
			n_tests, n_failed, n_errs, n_assert);
		if (n_errs == 0 && n_assert == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+.
vid_pkg.sv
apb_cfg_regs.sv
window_calc.sv
sync_recover.sv
video_out_mux.sv
video_sys_top.sv
video_sys_assertions.sv
tb_video_sys.sv

/* Makefile */
# Verilator simulation of the video sync and window system

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --assert -f compile.f --top-module tb_video_sys
	./obj_dir/Vtb_video_sys > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
